// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cpu -o tb_cpu

run: compile
	@out=$$(./obj_dir/tb_cpu +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/datapath_ctrl_if.sv
logic/idecoder.sv
logic/controller.sv
logic/datapath.sv
logic/cpu.sv
verif/cpu_props.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

// ==== logic/controller.sv ====
`default_nettype none

module controller (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::opcode_t   opcode,
    input  cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::reg_sel_t  reg_sel,
    output logic               load_pc,
    output logic               clear_pc,
    output logic               load_ir,
    output logic               load_addr,
    output logic               sel_addr,
    output logic               ram_w_en,
    output logic               halted,
    datapath_ctrl_if.ctrl      ctrl
);
    import cpu_pkg::*;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) state <= s_rst;
        else     state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            s_rst:    next_state = s_if1;
            s_if1:    next_state = s_if2;
            s_if2:    next_state = s_upc;
            s_upc:    next_state = s_decode;
            s_decode: begin
                case (opcode)
                    op_move:        next_state = (alu_op == alu_and) ? s_wr_imm : s_rd_b;
                    op_alu:         next_state = (alu_op == alu_mvn) ? s_rd_b : s_rd_a;
                    op_ldr, op_str: next_state = s_rd_a;
                    op_halt:        next_state = s_halt;
                    default:        next_state = s_if1; // Unknown opcode runs as a no-op
                endcase
            end
            s_wr_imm:  next_state = s_if1;
            s_rd_a:    next_state = (opcode inside {op_ldr, op_str}) ? s_mem_add : s_rd_b;
            s_rd_b:    next_state = (opcode == op_move) ? s_pass : s_exec;
            s_exec:    next_state = (alu_op == alu_cmp) ? s_if1 : s_wb;
            s_pass:    next_state = (opcode == op_str) ? s_str_wr : s_wb;
            s_wb:      next_state = s_if1;
            s_mem_add: next_state = s_ld_addr;
            s_ld_addr: next_state = (opcode == op_ldr) ? s_ld_wait : s_str_rd;
            s_ld_wait: next_state = s_ld_wb;
            s_ld_wb:   next_state = s_if1;
            s_str_rd:  next_state = s_pass;
            s_str_wr:  next_state = s_if1;
            s_halt:    next_state = s_halt; // Left only through rst
            default:   next_state = s_rst;
        endcase
    end

    // Moore outputs
    always_comb begin
        reg_sel        = sel_rn;
        load_pc        = 1'b0;
        clear_pc       = 1'b0;
        load_ir        = 1'b0;
        load_addr      = 1'b0;
        sel_addr       = 1'b1; // PC on the bus unless a data access is in progress
        ram_w_en       = 1'b0;
        halted         = 1'b0;
        ctrl.w_en      = 1'b0;
        ctrl.wb_sel    = wb_c;
        ctrl.en_a      = 1'b0;
        ctrl.en_b      = 1'b0;
        ctrl.en_c      = 1'b0;
        ctrl.en_status = 1'b0;
        ctrl.sel_a     = 1'b0;
        ctrl.sel_b     = 1'b0;
        case (state)
            s_rst: begin
                load_pc  = 1'b1;
                clear_pc = 1'b1;
            end
            s_if2:     load_ir = 1'b1;
            s_upc:     load_pc = 1'b1;
            s_wr_imm: begin
                reg_sel     = sel_rn;
                ctrl.wb_sel = wb_imm8;
                ctrl.w_en   = 1'b1;
            end
            s_rd_a: begin
                reg_sel   = sel_rn;
                ctrl.en_a = 1'b1;
            end
            s_rd_b: begin
                reg_sel   = sel_rm;
                ctrl.en_b = 1'b1;
            end
            s_exec: begin
                ctrl.en_c      = 1'b1;
                ctrl.en_status = 1'b1;
            end
            s_pass: begin // C gets the shifted B
                ctrl.sel_a = 1'b1;
                ctrl.en_c  = 1'b1;
            end
            s_wb: begin
                reg_sel   = sel_rd;
                ctrl.w_en = 1'b1;
            end
            s_mem_add: begin
                ctrl.sel_b = 1'b1;
                ctrl.en_c  = 1'b1;
            end
            s_ld_addr: load_addr = 1'b1;
            s_ld_wait: sel_addr = 1'b0;
            s_ld_wb: begin
                sel_addr    = 1'b0;
                reg_sel     = sel_rd;
                ctrl.wb_sel = wb_mdata;
                ctrl.w_en   = 1'b1;
            end
            s_str_rd: begin
                reg_sel   = sel_rd;
                ctrl.en_b = 1'b1;
            end
            s_str_wr: begin
                sel_addr = 1'b0;
                ram_w_en = 1'b1;
            end
            s_halt:    halted = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`default_nettype none

`include "cpu_settings.svh"

module cpu (
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W-1:0] start_pc,
    input  logic [`WORD_W-1:0] ram_r_data,
    output logic [`WORD_W-1:0] out,
    output logic               ram_w_en,
    output logic [`ADDR_W-1:0] ram_addr,
    output logic [`WORD_W-1:0] ram_w_data,
    output logic               halted
);
    import cpu_pkg::*;

    localparam int RW = $clog2(`NUM_REGS);

    logic [`WORD_W-1:0] ir;
    logic [`ADDR_W-1:0] pc;
    logic [`ADDR_W-1:0] next_pc;
    logic [`ADDR_W-1:0] data_addr;
    opcode_t            opcode;
    alu_op_t            alu_op;
    shift_op_t          shift_op;
    reg_sel_t           reg_sel;
    logic [RW-1:0]      r_addr;
    logic [RW-1:0]      w_addr;
    logic [`WORD_W-1:0] sximm5;
    logic [`WORD_W-1:0] sximm8;
    logic               load_pc;
    logic               clear_pc;
    logic               load_ir;
    logic               load_addr;
    logic               sel_addr;

    datapath_ctrl_if dp_ctrl ();

    idecoder idecoder_inst (
        .ir(ir), .reg_sel(reg_sel), .opcode(opcode), .alu_op(alu_op), .shift_op(shift_op),
        .r_addr(r_addr), .w_addr(w_addr), .sximm5(sximm5), .sximm8(sximm8)
    );

    controller controller_inst (
        .clk(clk), .rst(rst), .opcode(opcode), .alu_op(alu_op), .reg_sel(reg_sel),
        .load_pc(load_pc), .clear_pc(clear_pc), .load_ir(load_ir), .load_addr(load_addr),
        .sel_addr(sel_addr), .ram_w_en(ram_w_en), .halted(halted), .ctrl(dp_ctrl.ctrl)
    );

    // Status flags stay internal until branches exist
    datapath datapath_inst (
        .clk(clk), .mdata(ram_r_data), .pc(pc), .r_addr(r_addr), .w_addr(w_addr),
        .alu_op(alu_op), .shift_op(shift_op), .sximm5(sximm5), .sximm8(sximm8),
        .dp(dp_ctrl.dp), .datapath_out(out),
        .status_n(), .status_v(), .status_z()
    );

    assign ram_w_data = out;
    assign next_pc    = clear_pc ? start_pc : pc + 1'b1; // Wraps within ADDR_W
    assign ram_addr   = sel_addr ? pc : data_addr;

    always_ff @(posedge clk) begin
        if (load_ir)   ir        <= ram_r_data;
        if (load_pc)   pc        <= next_pc;
        if (load_addr) data_addr <= out[`ADDR_W-1:0];
    end

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Instruction bits [15:13]
    typedef enum logic [2:0] {
        op_move = 3'b110,
        op_alu  = 3'b101,
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_halt = 3'b111
    } opcode_t;

    // Instruction bits [12:11]
    typedef enum logic [1:0] {
        alu_add = 2'b00, // also MOV register
        alu_cmp = 2'b01,
        alu_and = 2'b10, // also MOV immediate
        alu_mvn = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        sh_none = 2'b00,
        sh_lsl  = 2'b01,
        sh_lsr  = 2'b10,
        sh_asr  = 2'b11
    } shift_op_t;

    typedef enum logic [1:0] {sel_rn = 2'b00, sel_rd = 2'b01, sel_rm = 2'b10} reg_sel_t;

    typedef enum logic [1:0] {wb_c = 2'b00, wb_imm8 = 2'b01, wb_mdata = 2'b10, wb_pc = 2'b11} wb_sel_t;

    typedef enum logic [4:0] {
        s_rst, s_if1, s_if2, s_upc, s_decode,
        s_wr_imm, s_rd_a, s_rd_b, s_exec, s_pass, s_wb,
        s_mem_add, s_ld_addr, s_ld_wait, s_ld_wb, s_str_rd, s_str_wr,
        s_halt
    } state_t;

endpackage

`default_nettype wire

// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and instruction word
`define WORD_W 16

// RAM address width, also the PC width
`define ADDR_W 8

// General registers R0 to R7
`define NUM_REGS 8

`endif

// ==== logic/datapath.sv ====
`default_nettype none

`include "cpu_settings.svh"

module datapath (
    input  logic                         clk,
    input  logic [`WORD_W-1:0]           mdata,
    input  logic [`ADDR_W-1:0]           pc,
    input  logic [$clog2(`NUM_REGS)-1:0] r_addr,
    input  logic [$clog2(`NUM_REGS)-1:0] w_addr,
    input  cpu_pkg::alu_op_t             alu_op,
    input  cpu_pkg::shift_op_t           shift_op,
    input  logic [`WORD_W-1:0]           sximm5,
    input  logic [`WORD_W-1:0]           sximm8,
    datapath_ctrl_if.dp                  dp,
    output logic [`WORD_W-1:0]           datapath_out,
    output logic                         status_n,
    output logic                         status_v,
    output logic                         status_z
);
    import cpu_pkg::*;

    localparam int MSB = `WORD_W - 1;

    logic [`WORD_W-1:0] regs [`NUM_REGS];
    logic [`WORD_W-1:0] w_data;
    logic [`WORD_W-1:0] r_data;
    logic [`WORD_W-1:0] a_reg;
    logic [`WORD_W-1:0] b_reg;
    logic [`WORD_W-1:0] c_reg;
    logic [`WORD_W-1:0] b_shift;
    logic [`WORD_W-1:0] ain;
    logic [`WORD_W-1:0] bin;
    logic [`WORD_W-1:0] alu_out;
    logic               alu_v;

    always_comb begin
        case (dp.wb_sel)
            wb_c:     w_data = c_reg;
            wb_imm8:  w_data = sximm8;
            wb_mdata: w_data = mdata;
            default:  w_data = {{(`WORD_W-`ADDR_W){1'b0}}, pc};
        endcase
    end

    always_ff @(posedge clk) begin
        if (dp.w_en) regs[w_addr] <= w_data;
    end

    assign r_data = regs[r_addr];

    always_comb begin
        case (shift_op)
            sh_lsl:  b_shift = {b_reg[MSB-1:0], 1'b0};
            sh_lsr:  b_shift = {1'b0, b_reg[MSB:1]};
            sh_asr:  b_shift = {b_reg[MSB], b_reg[MSB:1]};
            default: b_shift = b_reg;
        endcase
    end

    assign ain = dp.sel_a ? '0 : a_reg;
    assign bin = dp.sel_b ? sximm5 : b_shift;

    always_comb begin
        alu_v = 1'b0;
        case (alu_op)
            alu_add: begin
                alu_out = ain + bin;
                alu_v   = (ain[MSB] == bin[MSB]) && (alu_out[MSB] != ain[MSB]);
            end
            alu_cmp: begin
                alu_out = ain - bin;
                alu_v   = (ain[MSB] != bin[MSB]) && (alu_out[MSB] != ain[MSB]);
            end
            alu_and: alu_out = ain & bin;
            default: alu_out = ~bin;
        endcase
    end

    always_ff @(posedge clk) begin
        if (dp.en_a) a_reg <= r_data;
        if (dp.en_b) b_reg <= r_data;
        if (dp.en_c) c_reg <= alu_out;
        if (dp.en_status) begin
            status_n <= alu_out[MSB];
            status_v <= alu_v;
            status_z <= (alu_out == '0);
        end
    end

    assign datapath_out = c_reg;

endmodule

`default_nettype wire

// ==== logic/datapath_ctrl_if.sv ====
`default_nettype none

interface datapath_ctrl_if;
    import cpu_pkg::*;

    logic    w_en;
    wb_sel_t wb_sel;
    logic    en_a;
    logic    en_b;
    logic    en_c;
    logic    en_status;
    logic    sel_a; // A operand forced to zero
    logic    sel_b; // B operand taken from sximm5

    modport ctrl (
        output w_en, wb_sel,
        output en_a, en_b, en_c, en_status,
        output sel_a, sel_b
    );

    modport dp (
        input w_en, wb_sel,
        input en_a, en_b, en_c, en_status,
        input sel_a, sel_b
    );

endinterface

`default_nettype wire

// ==== logic/idecoder.sv ====
`default_nettype none

`include "cpu_settings.svh"

module idecoder (
    input  logic [`WORD_W-1:0]           ir,
    input  cpu_pkg::reg_sel_t            reg_sel,
    output cpu_pkg::opcode_t             opcode,
    output cpu_pkg::alu_op_t             alu_op,
    output cpu_pkg::shift_op_t           shift_op,
    output logic [$clog2(`NUM_REGS)-1:0] r_addr,
    output logic [$clog2(`NUM_REGS)-1:0] w_addr,
    output logic [`WORD_W-1:0]           sximm5,
    output logic [`WORD_W-1:0]           sximm8
);
    import cpu_pkg::*;

    logic [2:0] rn;
    logic [2:0] rd;
    logic [2:0] rm;
    logic       is_mem;

    assign opcode = opcode_t'(ir[15:13]);
    assign rn     = ir[10:8];
    assign rd     = ir[7:5];
    assign rm     = ir[2:0];

    // Loads and stores reuse the shift field as offset bits, so the B path stays plain
    assign is_mem   = (opcode == op_ldr) || (opcode == op_str);
    assign alu_op   = is_mem ? alu_add : alu_op_t'(ir[12:11]);
    assign shift_op = is_mem ? sh_none : shift_op_t'(ir[4:3]);

    assign sximm5 = {{(`WORD_W-5){ir[4]}}, ir[4:0]};
    assign sximm8 = {{(`WORD_W-8){ir[7]}}, ir[7:0]};

    always_comb begin
        case (reg_sel)
            sel_rd:  r_addr = rd;
            sel_rm:  r_addr = rm;
            default: r_addr = rn;
        endcase
    end

    assign w_addr = r_addr; // Same field for read and write

endmodule

`default_nettype wire

// ==== verif/cpu_checker.sv ====
`default_nettype none

`include "cpu_settings.svh"

module cpu_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               ram_w_en,
    input  logic [`ADDR_W-1:0] ram_addr,
    input  logic [`WORD_W-1:0] ram_w_data,
    input  logic [`WORD_W-1:0] out,
    input  logic               halted,
    output int                 errors
);
    import cpu_pkg::*;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    localparam int MAX_STEPS = 64; // Well above the longest generated program

    word_t image [2**`ADDR_W];
    addr_t exp_addr [$];
    word_t exp_data [$];
    int    model_stores;
    int    writes;
    logic  halt_seen;

    initial begin
        errors    = 0;
        halt_seen = 1'b1; // Idle until the first program arrives
    end

    function automatic word_t shifted(word_t v, shift_op_t sh);
        case (sh)
            sh_lsl:  return v << 1;
            sh_lsr:  return v >> 1;
            sh_asr:  return word_t'($signed(v) >>> 1);
            default: return v;
        endcase
    endfunction

    task automatic load_word(input addr_t a, input word_t d);
        image[a] = d;
    endtask

    // Runs the whole program at instruction level and queues its stores
    task automatic start_model(input addr_t pc0);
        word_t      r [`NUM_REGS];
        word_t      ir;
        word_t      operand;
        addr_t      pc;
        addr_t      addr;
        logic [2:0] rn;
        logic [2:0] rd;
        int         steps;
        logic       done;
        exp_addr.delete();
        exp_data.delete();
        model_stores = 0;
        writes       = 0;
        halt_seen    = 1'b0;
        pc           = pc0;
        done         = 1'b0;
        steps        = 0;
        foreach (r[i]) r[i] = '0;
        while (!done && steps < MAX_STEPS) begin
            ir      = image[pc];
            pc      = pc + 1'b1;
            steps++;
            rn      = ir[10:8];
            rd      = ir[7:5];
            operand = shifted(r[ir[2:0]], shift_op_t'(ir[4:3]));
            addr    = addr_t'(r[rn] + word_t'($signed(ir[4:0])));
            case (opcode_t'(ir[15:13]))
                op_move: begin
                    if (ir[12:11] == 2'b10) r[rn] = word_t'($signed(ir[7:0]));
                    else r[rd] = operand;
                end
                op_alu: begin
                    case (alu_op_t'(ir[12:11]))
                        alu_add: r[rd] = r[rn] + operand;
                        alu_and: r[rd] = r[rn] & operand;
                        alu_mvn: r[rd] = ~operand;
                        default: ; // CMP only touches the flags
                    endcase
                end
                op_ldr:  r[rd] = image[addr];
                op_str: begin
                    image[addr] = r[rd];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[rd]);
                    model_stores++;
                end
                op_halt: done = 1'b1;
                default: ;
            endcase
        end
        if (!done) begin
            errors++;
            $display("Model found no HALT within %0d instructions", MAX_STEPS);
        end
    endtask

    task automatic check_store();
        addr_t a;
        word_t d;
        writes++;
        if (halt_seen) begin
            errors++;
            $display("RAM write after HALT at time %0t, address %h", $time, ram_addr);
        end else if (exp_addr.size() == 0) begin
            errors++;
            $display("Extra RAM write at time %0t, the model has no store left", $time);
        end else begin
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            if (ram_addr !== a || ram_w_data !== d || out !== d) begin
                errors++;
                $display("Fail at %0t: write %0d to %h with %h (out %h), expected %h with %h",
                         $time, writes, ram_addr, ram_w_data, out, a, d);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && ram_w_en) check_store();
        if (!rst && halted && !halt_seen) begin
            halt_seen = 1'b1;
            if (writes != model_stores || exp_addr.size() != 0) begin
                errors++;
                $display("Fail at %0t: halted after %0d writes, model made %0d stores",
                         $time, writes, model_stores);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/cpu_props.sv ====
`default_nettype none

`include "cpu_settings.svh"

module cpu_props (
    input logic               clk,
    input logic               rst,
    input logic [`ADDR_W-1:0] start_pc,
    input logic               ram_w_en,
    input logic [`ADDR_W-1:0] ram_addr,
    input logic               halted
);

    int fail_count = 0;

    // Reset state drives neither a write nor the halt flag
    reset_quiet: assert property (@(posedge clk) rst |=> !ram_w_en && !halted)
        else begin
            fail_count++;
            $error("write enable or halted high in the reset state");
        end

    first_fetch: assert property (@(posedge clk)
        $fell(rst) |=> (ram_addr == start_pc) && !ram_w_en && !halted)
        else begin
            fail_count++;
            $error("first address after reset is not start_pc");
        end

    no_write_halted: assert property (@(posedge clk) halted |=> !ram_w_en)
        else begin
            fail_count++;
            $error("RAM write while halted");
        end

    // Halt state is sticky and freezes the bus until reset
    halt_hold: assert property (@(posedge clk)
        halted && !rst |=> halted && $stable(ram_addr))
        else begin
            fail_count++;
            $error("halted dropped or ram_addr moved after HALT");
        end

endmodule

`default_nettype wire

// ==== verif/tb_cpu.sv ====
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu;
    import cpu_pkg::*;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    localparam int NUM_TESTS  = 8;
    localparam int MAX_CYCLES = NUM_TESTS * 40 * 10 + NUM_TESTS * 20; // Plus reset margin

    logic  clk;
    logic  rst;
    addr_t start_pc;
    word_t ram_r_data;
    word_t out;
    logic  ram_w_en;
    addr_t ram_addr;
    word_t ram_w_data;
    logic  halted;
    word_t mem [2**`ADDR_W];
    addr_t read_addr;
    addr_t code_addr;
    int    errors;
    int    cycles = 0;
    int    n_stores;
    int    n_passed = 0;

    cpu cpu_inst (
        .clk(clk), .rst(rst), .start_pc(start_pc), .ram_r_data(ram_r_data), .out(out),
        .ram_w_en(ram_w_en), .ram_addr(ram_addr), .ram_w_data(ram_w_data), .halted(halted)
    );

    cpu_checker checker_inst (
        .clk(clk), .rst(rst), .ram_w_en(ram_w_en), .ram_addr(ram_addr),
        .ram_w_data(ram_w_data), .out(out), .halted(halted), .errors(errors)
    );

    bind cpu cpu_props cpu_props_inst (
        .clk(clk), .rst(rst), .start_pc(start_pc), .ram_w_en(ram_w_en),
        .ram_addr(ram_addr), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Synchronous RAM, read data driven on the falling edge after the address edge
    always @(posedge clk) begin
        if (ram_w_en) mem[ram_addr] = ram_w_data;
        read_addr <= ram_addr;
    end

    always @(negedge clk) ram_r_data = mem[read_addr];

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: program did not halt");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic word_t imm_instr(logic [2:0] rn, logic [7:0] imm8);
        return {op_move, 2'b10, rn, imm8};
    endfunction

    // MOV register uses op 00, the same code as ADD
    function automatic word_t reg_instr(opcode_t opc, alu_op_t op, logic [2:0] rn,
                                        logic [2:0] rd, shift_op_t sh, logic [2:0] rm);
        return {opc, op, rn, rd, sh, rm};
    endfunction

    function automatic word_t mem_instr(opcode_t opc, logic [2:0] rd, logic [4:0] off);
        return {opc, 2'b00, 3'd7, rd, off}; // R7 is the base pointer
    endfunction

    task automatic place_word(input word_t w);
        mem[code_addr] = w;
        code_addr = code_addr + 1'b1; // Wraps like the PC
    endtask

    task automatic build_program(input addr_t pc0);
        addr_t      data_base;
        logic [2:0] rd;
        int         n_rand;
        data_base = pc0 + 8'd128; // Opposite half of the address space from the code
        for (int a = 0; a < 2**`ADDR_W; a++) mem[a] = {a[7:0], ~a[7:0]};
        for (int i = 0; i < 32; i++) mem[addr_t'(data_base + i)] = word_t'($urandom);
        code_addr = pc0;
        n_stores  = 0;
        for (int r = 0; r < 7; r++) place_word(imm_instr(3'(r), 8'($urandom)));
        place_word(imm_instr(3'd7, data_base + 8'd16)); // Offsets -16..15 stay in the region
        n_rand = $urandom_range(30, 20);
        repeat (n_rand) begin
            rd = 3'($urandom_range(6, 0));
            case ($urandom_range(6, 0))
                0: place_word(imm_instr(rd, 8'($urandom)));
                1: place_word(reg_instr(op_move, alu_add, 3'($urandom), rd,
                                        shift_op_t'(2'($urandom)), 3'($urandom)));
                2: place_word(reg_instr(op_alu, alu_op_t'(2'($urandom)), 3'($urandom), rd,
                                        shift_op_t'(2'($urandom)), 3'($urandom)));
                3, 4: place_word(mem_instr(op_ldr, rd, 5'($urandom)));
                default: begin
                    place_word(mem_instr(op_str, 3'($urandom), 5'($urandom)));
                    n_stores++;
                end
            endcase
        end
        place_word({op_halt, 13'd0});
    endtask

    task automatic run_test(input int t);
        addr_t pc0;
        int    errors_before;
        pc0 = (t == 0) ? addr_t'($urandom_range(255, 240)) : addr_t'($urandom);
        @(negedge clk);
        rst      = 1'b1;
        start_pc = pc0;
        build_program(pc0);
        errors_before = errors;
        for (int a = 0; a < 2**`ADDR_W; a++) checker_inst.load_word(addr_t'(a), mem[a]);
        checker_inst.start_model(pc0);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        while (!halted) @(negedge clk);
        repeat (2) @(negedge clk); // Checker sees the halt edge
        if (errors == errors_before) begin
            n_passed++;
            $display("Test %0d passed: start_pc %h, %0d stores", t, pc0, n_stores);
        end else begin
            $display("Test %0d failed: start_pc %h, %0d errors", t, pc0, errors - errors_before);
        end
    endtask

    initial begin
        rst        = 1'b1;
        start_pc   = '0;
        ram_r_data = '0;
        void'($urandom(32'h695de8a9));
        for (int t = 0; t < NUM_TESTS; t++) run_test(t);
        $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 NUM_TESTS, n_passed, NUM_TESTS - n_passed, cpu_inst.cpu_props_inst.fail_count);
        if (n_passed == NUM_TESTS && cpu_inst.cpu_props_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
